// ==== source/mdec_macros.svh ====
// Decoder width macros
`ifndef MDEC_MACROS_SVH
`define MDEC_MACROS_SVH
`default_nettype none

// Signed coefficient level carried in the low bits of a stream word
`define MDEC_LEVEL_W 10

// Scale field of a DC word, also the run field of an AC word
`define MDEC_SCALE_W 6

// One quant entry, four of them per 28-bit load word
`define MDEC_QUANT_W 7

// Column lanes, one per block column
`define MDEC_LANES 8

// Terminates the block
`define MDEC_EOB_CODE 16'hFE00

`default_nettype wire
`endif

// ==== source/mdecPkg.sv ====
// Decoder shared types
`default_nettype none

package mdecPkg;

	// Parser: next word is scale+DC, or run+AC level
	typedef enum logic
	{
		stWaitDc,
		stAc
	} streamState_t;

	// Drain: waiting for a block, or walking the 64 pixels
	typedef enum logic
	{
		drIdle,
		drOut
	} drainState_t;

	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] coef_t;
	// [0yyy0xxx] 8x8 address
	typedef logic [7:0] pixAddr_t;

endpackage

`default_nettype wire

// ==== source/streamInput.sv ====
// Run-length stream parser
`include "mdec_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module streamInput (
	input  wire                               clk,
	input  wire                               i_rstN,
	input  wire                               i_dataWrite,
	input  wire        [15:0]                 i_dataIn,
	input  wire                               i_freeze,
	output logic                              o_coefWrite,
	output logic       [5:0]                  o_coefIndex,
	output logic signed [`MDEC_LEVEL_W-1:0]   o_level,
	output logic       [`MDEC_SCALE_W-1:0]    o_scale,
	output logic                              o_isDc,
	output logic                              o_blockEnd
);

	mdecPkg::streamState_t state;

	// Running position with bit 6 set once the block has overshot index 63
	logic [6:0] pos;
	logic [7:0] nextPos;
	logic [`MDEC_SCALE_W-1:0] run;
	logic accept;
	logic isEob;

	// Words are taken only while the drain is not busy
	assign accept = i_dataWrite && !i_freeze;
	assign isEob = (i_dataIn == `MDEC_EOB_CODE);

	// Run sits in the top bits of an AC word
	assign run = i_dataIn[15 -: `MDEC_SCALE_W];
	assign nextPos = {1'b0, pos} + {2'b00, run} + 8'd1;

	// Index of the registered write
	assign o_coefIndex = pos[5:0];

	// ----------------------------------------------------------------------
	// Control of state, position and strobes
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			state <= mdecPkg::stWaitDc;
			pos <= '0;
			o_coefWrite <= 1'b0;
			o_blockEnd <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			o_coefWrite <= 1'b0;
			o_blockEnd <= 1'b0;
			if (accept)
			begin
				if (isEob)
				begin
					// End of block from either state
					o_blockEnd <= 1'b1;
					state <= mdecPkg::stWaitDc;
				end
				else if (state == mdecPkg::stWaitDc)
				begin
					// DC always lands at index 0
					pos <= '0;
					o_coefWrite <= 1'b1;
					state <= mdecPkg::stAc;
				end
				else if (nextPos < 8'd64)
				begin
					pos <= nextPos[6:0];
					o_coefWrite <= 1'b1;
				end
				else
				begin
					// Park past the end after an overshoot so later words write nothing
					pos <= 7'd64;
				end
			end
		end
	end

	// Payload of each write with the scale kept for the whole block
	always_ff @(posedge clk)
	begin
		if (accept && !isEob)
		begin
			o_level <= i_dataIn[`MDEC_LEVEL_W-1:0];
			o_isDc <= (state == mdecPkg::stWaitDc);
			if (state == mdecPkg::stWaitDc)
			begin
				o_scale <= i_dataIn[15 -: `MDEC_SCALE_W];
			end
		end
	end

	// Nothing may reach the lanes or the drain while the drain is busy
	noWordWhileFrozen: assert property (@(posedge clk) disable iff (!i_rstN)
		i_freeze |-> !o_coefWrite && !o_blockEnd);

endmodule

`default_nettype wire

// ==== source/dequantLane.sv ====
// Column dequantizing lane
`include "mdec_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module dequantLane #(
	parameter int LANE = 0
) (
	input  wire                               clk,
	input  wire                               i_rstN,
	input  wire                               i_quantWrt,
	input  wire        [3:0]                  i_quantAdr,
	input  wire        [4*`MDEC_QUANT_W-1:0]  i_quantValue,
	input  wire                               i_coefWrite,
	input  wire        [5:0]                  i_coefIndex,
	input  wire signed [`MDEC_LEVEL_W-1:0]    i_level,
	input  wire        [`MDEC_SCALE_W-1:0]    i_scale,
	input  wire                               i_isDc,
	input  wire                               i_clear,
	input  wire        [2:0]                  i_readRow,
	output mdecPkg::coef_t                    o_readValue
);

	// Wide enough for level x quant x scale plus sign
	localparam int PROD_W = `MDEC_LEVEL_W + `MDEC_QUANT_W + `MDEC_SCALE_W + 1;
	// Slot in a load word and which half of the row it covers
	localparam int ENTRY = LANE % 4;
	localparam logic HALF = (LANE / 4) != 0;
	localparam logic signed [PROD_W-1:0] SAT_MAX = 127;
	localparam logic signed [PROD_W-1:0] SAT_MIN = -128;

	// One quant entry and one coefficient per row
	logic [`MDEC_QUANT_W-1:0] quant [`MDEC_LANES];
	mdecPkg::coef_t coefs [`MDEC_LANES];

	logic ownWrite;
	logic signed [PROD_W-1:0] levelExt;
	logic signed [PROD_W-1:0] quantExt;
	logic signed [PROD_W-1:0] scaleExt;
	logic signed [PROD_W-1:0] prodDc;
	logic signed [PROD_W-1:0] prodAc;
	logic signed [PROD_W-1:0] result;
	mdecPkg::coef_t satValue;

	assign ownWrite = i_coefWrite && (i_coefIndex[2:0] == 3'(LANE));

	// ----------------------------------------------------------------------
	// Quant table slice
	// ----------------------------------------------------------------------
	// Load word covers indexes adr*4..adr*4+3, so row is adr[3:1]
	always_ff @(posedge clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			for (int r = 0; r < `MDEC_LANES; r++)
			begin
				quant[r] <= '0;
			end
		end
		else if (i_quantWrt && (i_quantAdr[0] == HALF))
		begin
			quant[i_quantAdr[3:1]] <= i_quantValue[ENTRY*`MDEC_QUANT_W +: `MDEC_QUANT_W];
		end
	end

	// ----------------------------------------------------------------------
	// Multiply, shift, saturate
	// ----------------------------------------------------------------------
	// Level sign-extends, quant and scale are unsigned
	assign levelExt = PROD_W'(i_level);
	assign quantExt = PROD_W'(quant[i_coefIndex[5:3]]);
	assign scaleExt = PROD_W'(i_scale);
	assign prodDc = levelExt * quantExt;
	assign prodAc = (prodDc * scaleExt) >>> 3;
	assign result = i_isDc ? prodDc : prodAc;

	always_comb
	begin
		if (result > SAT_MAX)
			satValue = 8'sd127;
		else if (result < SAT_MIN)
			satValue = -8'sd128;
		else
			satValue = result[7:0];
	end

	// Coefficient store, cleared after each drain
	always_ff @(posedge clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			for (int r = 0; r < `MDEC_LANES; r++)
			begin
				coefs[r] <= '0;
			end
		end
		else if (i_clear)
		begin
			for (int r = 0; r < `MDEC_LANES; r++)
			begin
				coefs[r] <= '0;
			end
		end
		else if (ownWrite)
		begin
			coefs[i_coefIndex[5:3]] <= satValue;
		end
	end

	assign o_readValue = coefs[i_readRow];

	// Parser is frozen while the drain clears, so a write here would be lost
	noWriteOnClear: assert property (@(posedge clk) disable iff (!i_rstN)
		!(i_clear && ownWrite));

endmodule

`default_nettype wire

// ==== source/blockDrain.sv ====
// Raster block drain
`include "mdec_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module blockDrain (
	input  wire                  clk,
	input  wire                  i_rstN,
	input  wire                  i_blockEnd,
	input  wire                  i_stopFill,
	input  wire                  i_bitSigned,
	input  wire mdecPkg::coef_t  i_laneValue [`MDEC_LANES],
	output logic [2:0]           o_readRow,
	output logic                 o_busy,
	output logic                 o_clearLanes,
	output logic                 o_pixelOut,
	output mdecPkg::pixAddr_t    o_pixelAddress,
	output mdecPkg::pixel_t      o_luma
);

	mdecPkg::drainState_t state;

	// Raster position, {row, column}
	logic [5:0] count;
	logic clearPulse;
	logic advance;
	mdecPkg::coef_t selected;
	mdecPkg::pixel_t lumaNext;

	// A stop cycle holds the position
	assign advance = (state == mdecPkg::drOut) && !i_stopFill;

	// Row goes to every lane, column picked here
	assign o_readRow = count[5:3];
	assign selected = i_laneValue[count[2:0]];

	// Unsigned output is +128, which is a flip of the sign bit
	assign lumaNext = i_bitSigned ? selected : {~selected[7], selected[6:0]};

	// Busy spans the clear cycle too
	assign o_busy = (state == mdecPkg::drOut) || clearPulse;
	assign o_clearLanes = clearPulse;

	// ----------------------------------------------------------------------
	// Drain FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			state <= mdecPkg::drIdle;
			count <= '0;
			clearPulse <= 1'b0;
			o_pixelOut <= 1'b0;
		end
		else
		begin
			o_pixelOut <= advance;
			clearPulse <= 1'b0;
			case (state)
				mdecPkg::drIdle:
				begin
					if (i_blockEnd)
					begin
						state <= mdecPkg::drOut;
						count <= '0;
					end
				end
				mdecPkg::drOut:
				begin
					if (!i_stopFill)
					begin
						count <= count + 6'd1;
						// Last pixel, lanes clear next cycle
						if (count == 6'd63)
						begin
							state <= mdecPkg::drIdle;
							clearPulse <= 1'b1;
						end
					end
				end
				default:
				begin
					state <= mdecPkg::drIdle;
				end
			endcase
		end
	end

	// Address and byte ride with the strobe
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			o_pixelAddress <= {1'b0, count[5:3], 1'b0, count[2:0]};
			o_luma <= lumaNext;
		end
	end

	// Parser must stay frozen for the whole drain
	noBlockWhileBusy: assert property (@(posedge clk) disable iff (!i_rstN)
		i_blockEnd |-> !o_busy);

endmodule

`default_nettype wire

// ==== source/mdecCore.sv ====
// Luma block decoder top
`include "mdec_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module mdecCore (
	input  wire                               clk,
	input  wire                               i_rstN,
	input  wire                               i_bitSigned,
	input  wire                               i_dataWrite,
	input  wire        [15:0]                 i_dataIn,
	input  wire                               i_quantWrt,
	input  wire        [3:0]                  i_quantAdr,
	input  wire        [4*`MDEC_QUANT_W-1:0]  i_quantValue,
	input  wire                               i_stopFill,
	output logic                              o_allowLoad,
	output logic                              o_pixelOut,
	output mdecPkg::pixAddr_t                 o_pixelAddress,
	output mdecPkg::pixel_t                   o_luma
);

	// Parser to lanes
	logic coefWrite;
	logic [5:0] coefIndex;
	logic signed [`MDEC_LEVEL_W-1:0] level;
	logic [`MDEC_SCALE_W-1:0] scale;
	logic isDc;
	logic blockEnd;

	// Drain side
	logic busy;
	logic clearLanes;
	logic [2:0] readRow;
	mdecPkg::coef_t laneValue [`MDEC_LANES];

	// Loading allowed only while nothing is draining
	assign o_allowLoad = !busy;

	streamInput streamInputInst (
		.clk         (clk),
		.i_rstN      (i_rstN),
		.i_dataWrite (i_dataWrite),
		.i_dataIn    (i_dataIn),
		.i_freeze    (busy),
		.o_coefWrite (coefWrite),
		.o_coefIndex (coefIndex),
		.o_level     (level),
		.o_scale     (scale),
		.o_isDc      (isDc),
		.o_blockEnd  (blockEnd)
	);

	// ----------------------------------------------------------------------
	// One lane per column
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < `MDEC_LANES; i++)
	begin : genLane
		dequantLane #(.LANE(i)) laneInst (
			.clk          (clk),
			.i_rstN       (i_rstN),
			.i_quantWrt   (i_quantWrt),
			.i_quantAdr   (i_quantAdr),
			.i_quantValue (i_quantValue),
			.i_coefWrite  (coefWrite),
			.i_coefIndex  (coefIndex),
			.i_level      (level),
			.i_scale      (scale),
			.i_isDc       (isDc),
			.i_clear      (clearLanes),
			.i_readRow    (readRow),
			.o_readValue  (laneValue[i])
		);
	end

	blockDrain blockDrainInst (
		.clk            (clk),
		.i_rstN         (i_rstN),
		.i_blockEnd     (blockEnd),
		.i_stopFill     (i_stopFill),
		.i_bitSigned    (i_bitSigned),
		.i_laneValue    (laneValue),
		.o_readRow      (readRow),
		.o_busy         (busy),
		.o_clearLanes   (clearLanes),
		.o_pixelOut     (o_pixelOut),
		.o_pixelAddress (o_pixelAddress),
		.o_luma         (o_luma)
	);

endmodule

`default_nettype wire

// ==== verification/mdecTbChecks.svh ====
// Testbench checks and stream drivers
`ifndef MDEC_TB_CHECKS_SVH
`define MDEC_TB_CHECKS_SVH

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic checkPixel(input mdecPkg::pixel_t got, input mdecPkg::pixel_t expected,
	input int n);
	if (got !== expected)
	begin
		$display("CHECK FAILED at %0d ns: pixel %0d luma %02h, expected %02h",
			$time, n, got, expected);
		errorCount++;
	end
endtask

task automatic checkAddr(input mdecPkg::pixAddr_t got, input mdecPkg::pixAddr_t expected,
	input int n);
	if (got !== expected)
	begin
		$display("CHECK FAILED at %0d ns: pixel %0d address %02h, expected %02h",
			$time, n, got, expected);
		errorCount++;
	end
endtask

task automatic checkLevel(input logic got, input logic expected, input string what);
	if (got !== expected)
	begin
		$display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, what, got, expected);
		errorCount++;
	end
endtask

task automatic checkCount(input int got, input int expected, input string what);
	if (got != expected)
	begin
		$display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
		errorCount++;
	end
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// ----------------------------------------------------------------------
// Stream drivers
// ----------------------------------------------------------------------
// Entry k of load word a is table index a*4+k
task automatic loadQuant();
	for (int a = 0; a < 16; a++)
	begin
		@(posedge clk);
		#2;
		quantWrt = 1'b1;
		quantAdr = 4'(a);
		for (int k = 0; k < 4; k++)
		begin
			quantValue[k*`MDEC_QUANT_W +: `MDEC_QUANT_W] = `MDEC_QUANT_W'(quantTable[a*4+k]);
		end
	end
	@(posedge clk);
	#2;
	quantWrt = 1'b0;
endtask

// Row words one per cycle followed by the end-of-block code
task automatic sendBlock(input int r);
	for (int k = 0; k <= ROW_COUNT[r]; k++)
	begin
		@(posedge clk);
		#2;
		bitSigned = ROW_SIGNED[r];
		dataWrite = 1'b1;
		dataIn = (k < ROW_COUNT[r]) ? ROW_WORDS[r][k] : `MDEC_EOB_CODE;
	end
endtask

`endif

// ==== verification/mdecTb.sv ====
// Luma block decoder testbench
`include "mdec_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module mdecTb;

	localparam int ROWS = 6;
	localparam int MAX_WORDS = 16;
	// Stop cycles allowed per block
	localparam int MAX_PAUSE = 64;
	// Reset and quant load ahead of the first block
	localparam int SETUP_CYCLES = 40;
	localparam int CYCLE_LIMIT = ROWS * (MAX_WORDS + 64 + MAX_PAUSE + 10) + SETUP_CYCLES;

	// ----------------------------------------------------------------------
	// Stimulus table of {run or scale[5:0], level[9:0]} words
	// ----------------------------------------------------------------------
	// 0 DC only, 1 runs and overshoot, 2 saturation, 3 row 1 unsigned,
	// 4 stop pulses, 5 second block after a full one
	localparam bit ROW_SIGNED [ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
	localparam bit ROW_PAUSE [ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	localparam int ROW_COUNT [ROWS] = '{1, 6, 4, 6, 4, 1};
	localparam logic [15:0] ROW_WORDS [ROWS][MAX_WORDS] = '{
		'{16'h1005, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h2002, 16'h0003, 16'h17FE, 16'h5001, 16'hA007, 16'h0009, 16'h0000, 16'h0000,
		  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'hFDFF, 16'h0200, 16'h052C, 16'h03FF, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h2002, 16'h0003, 16'h17FE, 16'h5001, 16'hA007, 16'h0009, 16'h0000, 16'h0000,
		  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h0BFD, 16'h080A, 16'h27F9, 16'hC404, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h07FF, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};

	// DUT inputs
	logic clk;
	logic rstN;
	logic bitSigned;
	logic dataWrite;
	logic [15:0] dataIn;
	logic quantWrt;
	logic [3:0] quantAdr;
	logic [4*`MDEC_QUANT_W-1:0] quantValue;
	logic stopFill;

	// DUT outputs
	logic allowLoad;
	logic pixelOut;
	mdecPkg::pixAddr_t pixelAddress;
	mdecPkg::pixel_t luma;

	// Reference state
	int quantTable [64];
	mdecPkg::pixel_t expPix [64];
	logic [31:0] rng;
	int errorCount;
	int totalPixels;
	int cycleCount = 0;

	`include "mdecTbChecks.svh"

	mdecCore dut (
		.clk            (clk),
		.i_rstN         (rstN),
		.i_bitSigned    (bitSigned),
		.i_dataWrite    (dataWrite),
		.i_dataIn       (dataIn),
		.i_quantWrt     (quantWrt),
		.i_quantAdr     (quantAdr),
		.i_quantValue   (quantValue),
		.i_stopFill     (stopFill),
		.o_allowLoad    (allowLoad),
		.o_pixelOut     (pixelOut),
		.o_pixelAddress (pixelAddress),
		.o_luma         (luma)
	);

	always #10 clk = ~clk;

	// Run length bound
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout: no finish after %0d cycles", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic int saturate(input int v);
		if (v > 127)
			return 127;
		if (v < -128)
			return -128;
		return v;
	endfunction

	task automatic buildExpected(input int r);
		int coef [64];
		int idx;
		int scale;
		int lvl;
		logic [15:0] w;
		for (int i = 0; i < 64; i++)
		begin
			coef[i] = 0;
		end
		idx = 0;
		scale = 0;
		for (int k = 0; k < ROW_COUNT[r]; k++)
		begin
			w = ROW_WORDS[r][k];
			// Signed 10-bit level
			lvl = w[9] ? int'(w[9:0]) - 1024 : int'(w[9:0]);
			if (k == 0)
			begin
				// DC word holds the scale for the rest of the block
				scale = int'(w[15:10]);
				coef[0] = saturate(lvl * quantTable[0]);
			end
			else
			begin
				idx = idx + int'(w[15:10]) + 1;
				// Past index 63 nothing lands
				if (idx <= 63)
					coef[idx] = saturate((lvl * quantTable[idx] * scale) >>> 3);
			end
		end
		// Unsigned output is the coefficient plus 128 modulo 256
		for (int i = 0; i < 64; i++)
		begin
			expPix[i] = mdecPkg::pixel_t'(coef[i] + (ROW_SIGNED[r] ? 0 : 128));
		end
	endtask

	// ----------------------------------------------------------------------
	// One block through the DUT
	// ----------------------------------------------------------------------
	task automatic runBlock(input int r);
		int n;
		int stops;
		int startErrors;
		logic stopPrev;
		startErrors = errorCount;
		n = 0;
		stops = 0;
		stopPrev = 1'b0;
		buildExpected(r);
		sendBlock(r);
		while (n < 64)
		begin
			@(posedge clk);
			#2;
			dataWrite = 1'b0;
			rng = xorshift(rng);
			stopFill = ROW_PAUSE[r] && rng[0] && (stops < MAX_PAUSE);
			if (stopFill)
				stops++;
			@(negedge clk);
			// A stop cycle gives no strobe on the following edge
			if (stopPrev)
				checkLevel(pixelOut, 1'b0, "o_pixelOut after a stop cycle");
			if (pixelOut)
			begin
				checkPixel(luma, expPix[n], n);
				// Raster order in [0yyy0xxx] form
				checkAddr(pixelAddress, mdecPkg::pixAddr_t'((n / 8) * 16 + n % 8), n);
				n++;
			end
			// Loading stays shut from the first pixel to the clear
			if (n > 0)
				checkLevel(allowLoad, 1'b0, "o_allowLoad during drain");
			stopPrev = stopFill;
		end
		// Wait for loading to reopen while counting stray strobes
		while (!allowLoad)
		begin
			@(posedge clk);
			#2;
			stopFill = 1'b0;
			@(negedge clk);
			if (pixelOut)
				n++;
		end
		checkCount(n, 64, "pixel count");
		totalPixels += n;
		$display("Block %0d: signed %0b, %0d stop cycles, %0d pixels, %0d errors",
			r, ROW_SIGNED[r], stops, n, errorCount - startErrors);
	endtask

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		bitSigned = 1'b1;
		dataWrite = 1'b0;
		dataIn = '0;
		quantWrt = 1'b0;
		quantAdr = '0;
		quantValue = '0;
		stopFill = 1'b0;
		errorCount = 0;
		totalPixels = 0;
		rng = 32'd70;
		// Quant entries 1..127
		for (int i = 0; i < 64; i++)
		begin
			rng = xorshift(rng);
			quantTable[i] = int'(rng % 32'd127) + 1;
		end
		repeat (2) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(negedge clk);
		checkLevel(allowLoad, 1'b1, "o_allowLoad after reset");
		checkLevel(pixelOut, 1'b0, "o_pixelOut after reset");
		loadQuant();
		for (int r = 0; r < ROWS; r++)
		begin
			runBlock(r);
		end
		$display("Summary: %0d blocks, %0d pixels, %0d errors", ROWS, totalPixels, errorCount);
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
+incdir+verification
source/mdecPkg.sv
source/streamInput.sv
source/dequantLane.sv
source/blockDrain.sv
source/mdecCore.sv
verification/mdecTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mdecTb
FILELIST = all.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard source/*.sv source/*.svh verification/*.sv verification/*.svh)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG)
	cat $(LOG)

check: run
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
